// ==== accel_mem_bridge.f ====
+incdir+.
accel_bridge_pkg.sv
accel_bridge_ifs.sv
mem_req_router.sv
mem_rsp_merge.sv
csr_run_control.sv
accel_mem_bridge.sv
tb_accel_mem_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module tb_accel_mem_bridge \
    -f accel_mem_bridge.f \
    -o sim_bridge > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build error, see build.log"
    exit 1
fi

./obj_dir/sim_bridge > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    exit 0
fi
echo "no pass line in sim.log"
exit 1

// ==== tb_accel_mem_bridge.sv ====
/*
    directed testbench for the accelerator memory bridge: LFSR stimulus,
    typed compare tasks, one task per behavior
*/

`timescale 1ns/1ps
`default_nettype none

`include "accel_bridge_settings.svh"

module tb_accel_mem_bridge;

    import accel_bridge_pkg::*;

    // line address of the window base
    localparam logic [31:0] BASE_LINE = `LOCAL_MEM_BASE >> `BRIDGE_LINE_BITS;

    logic                           clk;
    logic                           reset;
    logic                           acc_req_valid;
    mem_req_t                       acc_req;
    logic                           acc_req_ready;
    logic                           acc_rsp_valid;
    mem_rsp_t                       acc_rsp;
    logic                           acc_rsp_ready;
    logic                           local_req_valid;
    mem_req_t                       local_req;
    logic                           local_req_ready;
    logic                           local_rsp_valid;
    mem_rsp_t                       local_rsp;
    logic                           local_rsp_ready;
    logic                           ext_req_valid;
    mem_req_t                       ext_req;
    logic                           ext_req_ready;
    logic                           ext_rsp_valid;
    mem_rsp_t                       ext_rsp;
    logic                           ext_rsp_ready;
    logic                           csr_wen;
    logic                           csr_ren;
    logic [`CSR_ADDR_WIDTH-1:0]     csr_addr;
    logic [31:0]                    csr_wdata;
    logic [3:0]                     csr_strobe;
    logic [31:0]                    csr_rdata;
    logic                           accel_busy;
    logic                           accel_reset;
    logic [31:0]                    pc_reset_val;
    logic [31:0]                    lfsr_state;

    accel_mem_bridge dut (.*);

    // 20 ns period
    always #10 clk = ~clk;

    //////////////////////////////////////////////////////////////////////////
    // random source and reference rules
    //////////////////////////////////////////////////////////////////////////

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    // byte address range test against the local window
    function automatic logic in_local_window(input logic [`BRIDGE_ADDR_WIDTH-1:0] line_addr);
        logic [32:0] byte_addr;
        logic [32:0] lo;
        byte_addr = {1'b0, line_addr, {`BRIDGE_LINE_BITS{1'b0}}};
        lo = {1'b0, `LOCAL_MEM_BASE};
        return (byte_addr >= lo) && (byte_addr < lo + (33'd1 << `LOCAL_MEM_SPACE_BITS));
    endfunction

    task automatic make_req(input logic in_window, output mem_req_t r);
        logic [63:0] v;
        take_bits(1, v);
        r.rw = v[0];
        take_bits(`BRIDGE_BYTEEN_WIDTH, v);
        r.byteen = v[`BRIDGE_BYTEEN_WIDTH-1:0];
        if (in_window)
        begin
            // offset bits below the window size only
            take_bits(`LOCAL_MEM_SPACE_BITS - `BRIDGE_LINE_BITS, v);
            r.addr = BASE_LINE[`BRIDGE_ADDR_WIDTH-1:0] | v[`BRIDGE_ADDR_WIDTH-1:0];
        end
        else
        begin
            take_bits(`BRIDGE_ADDR_WIDTH, v);
            r.addr = v[`BRIDGE_ADDR_WIDTH-1:0];
        end
        take_bits(`BRIDGE_DATA_WIDTH, v);
        r.data = v;
        take_bits(`BRIDGE_TAG_WIDTH, v);
        r.tag = v[`BRIDGE_TAG_WIDTH-1:0];
    endtask

    task automatic make_rsp(output mem_rsp_t r);
        logic [63:0] v;
        take_bits(`BRIDGE_DATA_WIDTH, v);
        r.data = v;
        take_bits(`BRIDGE_TAG_WIDTH, v);
        r.tag = v[`BRIDGE_TAG_WIDTH-1:0];
    endtask

    //////////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////////

    task automatic check_req(input string name, input mem_req_t got, input mem_req_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_rsp(input string name, input mem_rsp_t got, input mem_rsp_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_word(input string name, input csr_word_u got, input csr_word_u exp);
        if (got.word !== exp.word)
        begin
            $display("MISMATCH %s: got %h, expected %h", name, got.word, exp.word);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    //////////////////////////////////////////////////////////////////////////
    // bus helpers and waits
    //////////////////////////////////////////////////////////////////////////

    // one write cycle, returns at the following falling edge
    task automatic csr_write(input logic [`CSR_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                             input logic [3:0] strobe);
        csr_wen = 1'b1;
        csr_addr = addr;
        csr_wdata = data;
        csr_strobe = strobe;
        @(negedge clk);
        csr_wen = 1'b0;
    endtask

    // one read cycle, returns at the following falling edge
    task automatic csr_read_check(input string name, input logic [`CSR_ADDR_WIDTH-1:0] addr,
                                  input csr_word_u exp);
        csr_ren = 1'b1;
        csr_addr = addr;
        #2;
        check_word(name, csr_rdata, exp);
        @(negedge clk);
        csr_ren = 1'b0;
    endtask

    task automatic wait_reset_level(input logic level, input int expect_cycles);
        int n;
        n = 0;
        while (accel_reset !== level)
        begin
            if (n == 8)
            begin
                $display("timeout: accel_reset never reached %0b within 8 cycles", level);
                $display("test failed");
                $fatal(1);
            end
            @(negedge clk);
            n++;
        end
        if (n != expect_cycles)
        begin
            $display("accel_reset changed after %0d cycles instead of %0d", n, expect_cycles);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic drive_rsp(input logic lv, input mem_rsp_t lr, input logic ev,
                             input mem_rsp_t er, input logic rdy);
        local_rsp_valid = lv;
        local_rsp = lr;
        ext_rsp_valid = ev;
        ext_rsp = er;
        acc_rsp_ready = rdy;
    endtask

    //////////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////////

    task automatic test_after_reset();
        csr_read_check("csr_rdata busy", `CSR_BUSY_OFFSET, 32'd0);
        // one clock edge past reset, state alone holds the accelerator
        check_bit("accel_reset", accel_reset, 1'b1);
        check_word("pc_reset_val", pc_reset_val, `PC_RESET_DEFAULT);
        check_bit("acc_rsp_valid", acc_rsp_valid, 1'b0);
    endtask

    task automatic test_routing();
        mem_req_t r;
        logic [63:0] v;
        logic hit;
        for (int i = 0; i < 16; i++)
        begin
            // even rounds aim inside the window
            make_req(i[0] == 1'b0, r);
            take_bits(2, v);
            hit = in_local_window(r.addr);
            acc_req_valid = 1'b1;
            acc_req = r;
            local_req_ready = v[1];
            ext_req_ready = v[0];
            #2;
            check_bit("local_req_valid", local_req_valid, hit);
            check_bit("ext_req_valid", ext_req_valid, ~hit);
            check_req("local_req", local_req, r);
            check_req("ext_req", ext_req, r);
            check_bit("acc_req_ready", acc_req_ready, v[1] & v[0]);
            @(negedge clk);
        end
        // idle port
        acc_req_valid = 1'b0;
        #2;
        check_bit("local_req_valid", local_req_valid, 1'b0);
        check_bit("ext_req_valid", ext_req_valid, 1'b0);
        @(negedge clk);
    endtask

    task automatic test_rsp_merge();
        mem_rsp_t lr;
        mem_rsp_t er;
        mem_rsp_t none;
        none = '0;
        make_rsp(lr);
        make_rsp(er);
        // lone local, then lone external
        drive_rsp(1'b1, lr, 1'b0, none, 1'b1);
        #2;
        check_bit("acc_rsp_valid", acc_rsp_valid, 1'b1);
        check_rsp("acc_rsp", acc_rsp, lr);
        check_bit("local_rsp_ready", local_rsp_ready, 1'b1);
        check_bit("ext_rsp_ready", ext_rsp_ready, 1'b1);
        @(negedge clk);
        drive_rsp(1'b0, none, 1'b1, er, 1'b1);
        #2;
        check_bit("acc_rsp_valid", acc_rsp_valid, 1'b1);
        check_rsp("acc_rsp", acc_rsp, er);
        @(negedge clk);
        // lone responses leave nothing behind
        drive_rsp(1'b0, none, 1'b0, none, 1'b1);
        #2;
        check_bit("acc_rsp_valid", acc_rsp_valid, 1'b0);
        @(negedge clk);
        // collision, external follows one cycle later
        make_rsp(lr);
        make_rsp(er);
        drive_rsp(1'b1, lr, 1'b1, er, 1'b1);
        #2;
        check_rsp("acc_rsp", acc_rsp, lr);
        @(negedge clk);
        drive_rsp(1'b0, none, 1'b0, none, 1'b1);
        #2;
        check_bit("acc_rsp_valid", acc_rsp_valid, 1'b1);
        check_rsp("acc_rsp", acc_rsp, er);
        @(negedge clk);
        #2;
        check_bit("acc_rsp_valid", acc_rsp_valid, 1'b0);
        @(negedge clk);
        // buffered entry held while ready is low
        make_rsp(lr);
        make_rsp(er);
        drive_rsp(1'b1, lr, 1'b1, er, 1'b1);
        #2;
        check_rsp("acc_rsp", acc_rsp, lr);
        @(negedge clk);
        drive_rsp(1'b0, none, 1'b0, none, 1'b0);
        for (int k = 0; k < 3; k++)
        begin
            #2;
            check_bit("acc_rsp_valid", acc_rsp_valid, 1'b1);
            check_rsp("acc_rsp", acc_rsp, er);
            check_bit("local_rsp_ready", local_rsp_ready, 1'b0);
            check_bit("ext_rsp_ready", ext_rsp_ready, 1'b0);
            @(negedge clk);
        end
        acc_rsp_ready = 1'b1;
        #2;
        check_rsp("acc_rsp", acc_rsp, er);
        @(negedge clk);
        #2;
        check_bit("acc_rsp_valid", acc_rsp_valid, 1'b0);
        @(negedge clk);
    endtask

    task automatic test_registers();
        csr_word_u exp_pc;
        csr_word_u wd;
        logic [63:0] v;
        exp_pc.word = `PC_RESET_DEFAULT;
        for (int i = 0; i < 8; i++)
        begin
            take_bits(32, v);
            wd.word = v[31:0];
            take_bits(4, v);
            csr_write(`CSR_PC_OFFSET, wd.word, v[3:0]);
            // strobed bytes replace, others keep
            for (int b = 0; b < 4; b++)
            begin
                if (v[b])
                begin
                    exp_pc.word[8*b +: 8] = wd.word[8*b +: 8];
                end
            end
            csr_read_check("csr_rdata pc", `CSR_PC_OFFSET, exp_pc);
            check_word("pc_reset_val", pc_reset_val, exp_pc);
        end
        // go clear, stays halted
        take_bits(32, v);
        wd.word = v[31:0];
        wd.start.go = 1'b0;
        csr_write(`CSR_START_OFFSET, wd.word, 4'hf);
        check_bit("accel_reset", accel_reset, 1'b1);
        @(negedge clk);
        check_bit("accel_reset", accel_reset, 1'b1);
        // go set, byte 0 only
        wd.start.go = 1'b1;
        csr_wen = 1'b1;
        csr_addr = `CSR_START_OFFSET;
        csr_wdata = wd.word;
        csr_strobe = 4'b0001;
        #2;
        check_bit("accel_reset", accel_reset, 1'b1);
        wait_reset_level(1'b0, 1);
        csr_wen = 1'b0;
    endtask

    task automatic test_run_stop();
        accel_busy = 1'b1;
        // registered busy, still zero in this cycle
        csr_read_check("csr_rdata busy", `CSR_BUSY_OFFSET, 32'd0);
        csr_read_check("csr_rdata busy", `CSR_BUSY_OFFSET, 32'd1);
        check_bit("accel_reset", accel_reset, 1'b0);
        // falling busy halts on the next edge
        accel_busy = 1'b0;
        #2;
        check_bit("accel_reset", accel_reset, 1'b0);
        wait_reset_level(1'b1, 1);
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        lfsr_state = 32'haade_d017;
        acc_req_valid = 1'b0;
        acc_req = '0;
        acc_rsp_ready = 1'b0;
        local_req_ready = 1'b0;
        local_rsp_valid = 1'b0;
        local_rsp = '0;
        ext_req_ready = 1'b0;
        ext_rsp_valid = 1'b0;
        ext_rsp = '0;
        csr_wen = 1'b0;
        csr_ren = 1'b0;
        csr_addr = '0;
        csr_wdata = '0;
        csr_strobe = '0;
        accel_busy = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_after_reset();
        test_routing();
        test_rsp_merge();
        test_registers();
        test_run_stop();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== accel_mem_bridge.sv ====
/*
    bridge top: accelerator memory port to local memory and external
    target, plus the run control register block
*/

`timescale 1ns/1ps
`default_nettype none

`include "accel_bridge_settings.svh"

module accel_mem_bridge (
    input  logic                           clk,
    input  logic                           reset,

    //////////////////////////////////////////////////////////////////////////////
    // accelerator memory port
    //////////////////////////////////////////////////////////////////////////////

    input  logic                           acc_req_valid,
    input  accel_bridge_pkg::mem_req_t     acc_req,
    output logic                           acc_req_ready,
    output logic                           acc_rsp_valid,
    output accel_bridge_pkg::mem_rsp_t     acc_rsp,
    input  logic                           acc_rsp_ready,

    //////////////////////////////////////////////////////////////////////////////
    // local memory
    //////////////////////////////////////////////////////////////////////////////

    output logic                           local_req_valid,
    output accel_bridge_pkg::mem_req_t     local_req,
    input  logic                           local_req_ready,
    input  logic                           local_rsp_valid,
    input  accel_bridge_pkg::mem_rsp_t     local_rsp,
    output logic                           local_rsp_ready,

    //////////////////////////////////////////////////////////////////////////////
    // external bus manager
    //////////////////////////////////////////////////////////////////////////////

    output logic                           ext_req_valid,
    output accel_bridge_pkg::mem_req_t     ext_req,
    input  logic                           ext_req_ready,
    input  logic                           ext_rsp_valid,
    input  accel_bridge_pkg::mem_rsp_t     ext_rsp,
    output logic                           ext_rsp_ready,

    // register bus
    input  logic                           csr_wen,
    input  logic                           csr_ren,
    input  logic [`CSR_ADDR_WIDTH-1:0]     csr_addr,
    input  logic [31:0]                    csr_wdata,
    input  logic [3:0]                     csr_strobe,
    output logic [31:0]                    csr_rdata,

    // run control
    input  logic                           accel_busy,
    output logic                           accel_reset,
    output logic [31:0]                    pc_reset_val
);

    // request side channels
    mem_req_if  acc_req_ch ();
    mem_req_if  local_req_ch ();
    mem_req_if  ext_req_ch ();

    // response side channels
    mem_rsp_if  acc_rsp_ch ();
    mem_rsp_if  local_rsp_ch ();
    mem_rsp_if  ext_rsp_ch ();

    csr_bus_if  csr_ch ();

    // accelerator port
    assign acc_req_ch.valid = acc_req_valid;
    assign acc_req_ch.req = acc_req;
    assign acc_req_ready = acc_req_ch.ready;
    assign acc_rsp_valid = acc_rsp_ch.valid;
    assign acc_rsp = acc_rsp_ch.rsp;
    assign acc_rsp_ch.ready = acc_rsp_ready;

    // local memory port
    assign local_req_valid = local_req_ch.valid;
    assign local_req = local_req_ch.req;
    assign local_req_ch.ready = local_req_ready;
    assign local_rsp_ch.valid = local_rsp_valid;
    assign local_rsp_ch.rsp = local_rsp;
    assign local_rsp_ready = local_rsp_ch.ready;

    // external port
    assign ext_req_valid = ext_req_ch.valid;
    assign ext_req = ext_req_ch.req;
    assign ext_req_ch.ready = ext_req_ready;
    assign ext_rsp_ch.valid = ext_rsp_valid;
    assign ext_rsp_ch.rsp = ext_rsp;
    assign ext_rsp_ready = ext_rsp_ch.ready;

    // register bus
    assign csr_ch.wen = csr_wen;
    assign csr_ch.ren = csr_ren;
    assign csr_ch.addr = csr_addr;
    assign csr_ch.wdata = csr_wdata;
    assign csr_ch.strobe = csr_strobe;
    assign csr_rdata = csr_ch.rdata;

    mem_req_router u_router (
        .acc        (acc_req_ch),
        .local_tgt  (local_req_ch),
        .ext_tgt    (ext_req_ch)
    );

    mem_rsp_merge u_merge (
        .clk        (clk),
        .reset      (reset),
        .local_rsp  (local_rsp_ch),
        .ext_rsp    (ext_rsp_ch),
        .acc        (acc_rsp_ch)
    );

    csr_run_control u_csr (
        .clk            (clk),
        .reset          (reset),
        .bus            (csr_ch),
        .accel_busy     (accel_busy),
        .accel_reset    (accel_reset),
        .pc_reset_val   (pc_reset_val)
    );

endmodule

`default_nettype wire

// ==== csr_run_control.sv ====
/*
    register block (busy, start, pc reset value) and the run/stop FSM
    that holds the accelerator in reset
*/

`timescale 1ns/1ps
`default_nettype none

`include "accel_bridge_settings.svh"

module csr_run_control (
    input  logic            clk,
    input  logic            reset,
    // peripheral register bus
    csr_bus_if.peripheral   bus,
    // status from the accelerator
    input  logic            accel_busy,
    // reset into the accelerator
    output logic            accel_reset,
    // boot address for the accelerator
    output logic [31:0]     pc_reset_val
);

    import accel_bridge_pkg::*;

    localparam logic [`CSR_ADDR_WIDTH-1:0] BUSY_OFF  = `CSR_BUSY_OFFSET;
    localparam logic [`CSR_ADDR_WIDTH-1:0] START_OFF = `CSR_START_OFFSET;
    localparam logic [`CSR_ADDR_WIDTH-1:0] PC_OFF    = `CSR_PC_OFFSET;

    // run/stop state encoding
    localparam logic ST_RUN  = 1'b0;
    localparam logic ST_HALT = 1'b1;

    logic       state;
    logic       state_next;
    // accel_busy from the previous cycle
    logic       busy_q;
    logic       start_hit;
    csr_word_u  wr_word;
    csr_word_u  rd_word;

    assign wr_word.word = bus.wdata;

    // start needs go set and byte 0 enabled
    assign start_hit = bus.wen & (bus.addr == START_OFF) & bus.strobe[0] & wr_word.start.go;

    //////////////////////////////////////////////////////////////////////////////
    // register read/write
    //////////////////////////////////////////////////////////////////////////////

    // reads return zero unless ren, start reads as zero
    always_comb
    begin
        rd_word.word = '0;
        if (bus.ren)
        begin
            if (bus.addr == BUSY_OFF)
            begin
                rd_word.word = {31'b0, busy_q};
            end
            else if (bus.addr == PC_OFF)
            begin
                rd_word.word = pc_reset_val;
            end
        end
    end

    assign bus.rdata = rd_word.word;

    // byte merge under strobe
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc_reset_val <= `PC_RESET_DEFAULT;
        end
        else if (bus.wen & (bus.addr == PC_OFF))
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (bus.strobe[i])
                begin
                    pc_reset_val[8*i +: 8] <= wr_word.word[8*i +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // run/stop FSM
    //////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        case (state)
            // accelerator held in reset until start
            ST_HALT:
            begin
                if (start_hit)
                begin
                    state_next = ST_RUN;
                end
            end
            // falling busy ends the run
            default:
            begin
                if (~accel_busy & busy_q)
                begin
                    state_next = ST_HALT;
                end
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_HALT;
            busy_q <= 1'b0;
        end
        else
        begin
            state <= state_next;
            busy_q <= accel_busy;
        end
    end

    assign accel_reset = reset | state;

endmodule

`default_nettype wire

// ==== mem_rsp_merge.sv ====
/*
    response merge: local response first, external next, one-entry
    buffer for the external response lost in a collision
*/

`timescale 1ns/1ps
`default_nettype none

module mem_rsp_merge (
    input  logic            clk,
    input  logic            reset,
    // local memory responses
    mem_rsp_if.accel        local_rsp,
    // external bus manager responses
    mem_rsp_if.accel        ext_rsp,
    // merged stream to the accelerator
    mem_rsp_if.target       acc
);

    import accel_bridge_pkg::*;

    // collision buffer
    logic       buf_valid;
    mem_rsp_t   buf_rsp;

    // both targets answer in the same cycle
    logic       collide;
    // no direct response, buffer owns the output
    logic       show_buf;

    assign collide = local_rsp.valid & ext_rsp.valid;
    assign show_buf = ~local_rsp.valid & ~ext_rsp.valid;

    //////////////////////////////////////////////////////////////////////////////
    // output select
    //////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        if (local_rsp.valid)
        begin
            // local wins, also on a collision
            acc.valid = 1'b1;
            acc.rsp = local_rsp.rsp;
        end
        else if (ext_rsp.valid)
        begin
            // chosen by its own valid
            acc.valid = 1'b1;
            acc.rsp = ext_rsp.rsp;
        end
        else
        begin
            acc.valid = buf_valid;
            acc.rsp = buf_rsp;
        end
    end

    // accelerator ready goes to both targets as is
    assign local_rsp.ready = acc.ready;
    assign ext_rsp.ready = acc.ready;

    //////////////////////////////////////////////////////////////////////////////
    // collision buffer
    //////////////////////////////////////////////////////////////////////////////

    // capture when the external target sees its response taken
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            buf_valid <= 1'b0;
        end
        else if (collide & acc.ready)
        begin
            buf_valid <= 1'b1;
        end
        else if (show_buf & acc.ready)
        begin
            // drained once presented with ready high
            buf_valid <= 1'b0;
        end
    end

    // payload only, qualified by buf_valid
    always_ff @(posedge clk)
    begin
        if (collide & acc.ready)
        begin
            buf_rsp <= ext_rsp.rsp;
        end
    end

endmodule

`default_nettype wire

// ==== mem_req_router.sv ====
/*
    request router: steers each accelerator request to the local memory
    or to the external target by line address
*/

`timescale 1ns/1ps
`default_nettype none

`include "accel_bridge_settings.svh"

module mem_req_router (
    // from the accelerator
    mem_req_if.target       acc,
    // to local memory
    mem_req_if.requester    local_tgt,
    // to the external bus manager
    mem_req_if.requester    ext_tgt
);

    // byte address width rebuilt from the line address
    localparam int BYTE_ADDR_WIDTH = `BRIDGE_ADDR_WIDTH + `BRIDGE_LINE_BITS;
    // lowest line address bit that lies above the window
    localparam int WIN_LSB = `LOCAL_MEM_SPACE_BITS - `BRIDGE_LINE_BITS;
    localparam int WIN_BITS = `BRIDGE_ADDR_WIDTH - WIN_LSB;
    localparam logic [BYTE_ADDR_WIDTH-1:0] BASE_BYTE = `LOCAL_MEM_BASE;

    // window tag of the local memory
    logic [WIN_BITS-1:0] base_tag;
    // request falls inside the local window
    logic                local_hit;

    assign base_tag = BASE_BYTE[BYTE_ADDR_WIDTH-1:`LOCAL_MEM_SPACE_BITS];
    assign local_hit = (acc.req.addr[`BRIDGE_ADDR_WIDTH-1:WIN_LSB] == base_tag);

    // only valid is steered, exactly one target sees it
    always_comb
    begin
        local_tgt.valid = 1'b0;
        ext_tgt.valid = 1'b0;
        if (acc.valid)
        begin
            if (local_hit)
            begin
                local_tgt.valid = 1'b1;
            end
            else
            begin
                ext_tgt.valid = 1'b1;
            end
        end
    end

    // payload fans out to both sides unchanged
    assign local_tgt.req = acc.req;
    assign ext_tgt.req = acc.req;

    // accept only when both targets can take a request
    assign acc.ready = local_tgt.ready & ext_tgt.ready;

endmodule

`default_nettype wire

// ==== accel_bridge_ifs.sv ====
/*
    bridge interfaces: memory request channel, memory response channel
    and the peripheral register bus
*/

`timescale 1ns/1ps
`default_nettype none

`include "accel_bridge_settings.svh"

//////////////////////////////////////////////////////////////////////////////
// request channel, valid/ready handshake
//////////////////////////////////////////////////////////////////////////////

interface mem_req_if;
    import accel_bridge_pkg::*;

    logic       valid;
    mem_req_t   req;
    logic       ready;

    // side that issues requests
    modport requester (output valid, req, input ready);
    // side that accepts them
    modport target (input valid, req, output ready);
endinterface

//////////////////////////////////////////////////////////////////////////////
// response channel, valid/ready handshake
//////////////////////////////////////////////////////////////////////////////

interface mem_rsp_if;
    import accel_bridge_pkg::*;

    logic       valid;
    mem_rsp_t   rsp;
    logic       ready;

    // memory side produces the response
    modport target (output valid, rsp, input ready);
    // accelerator side consumes it
    modport accel (input valid, rsp, output ready);
endinterface

//////////////////////////////////////////////////////////////////////////////
// register bus, no wait states, no error
//////////////////////////////////////////////////////////////////////////////

interface csr_bus_if;
    logic                         wen;
    logic                         ren;
    logic [`CSR_ADDR_WIDTH-1:0]   addr;
    logic [31:0]                  wdata;
    // byte enables for wdata
    logic [3:0]                   strobe;
    logic [31:0]                  rdata;

    modport bus (output wen, ren, addr, wdata, strobe, input rdata);
    modport peripheral (input wen, ren, addr, wdata, strobe, output rdata);
endinterface

`default_nettype wire

// ==== accel_bridge_pkg.sv ====
/*
    shared types of the accelerator memory bridge: memory request,
    memory response and the register word
*/

`default_nettype none

`include "accel_bridge_settings.svh"

package accel_bridge_pkg;

    // accelerator memory request, 110 bits
    typedef struct packed {
        // 1 = write
        logic                              rw;
        logic [`BRIDGE_BYTEEN_WIDTH-1:0]   byteen;
        // line address
        logic [`BRIDGE_ADDR_WIDTH-1:0]     addr;
        logic [`BRIDGE_DATA_WIDTH-1:0]     data;
        logic [`BRIDGE_TAG_WIDTH-1:0]      tag;
    } mem_req_t;

    // memory response, 72 bits
    typedef struct packed {
        logic [`BRIDGE_DATA_WIDTH-1:0]     data;
        // echoes the request tag
        logic [`BRIDGE_TAG_WIDTH-1:0]      tag;
    } mem_rsp_t;

    // start command layout, only bit 0 means anything
    typedef struct packed {
        logic [30:0]                       reserved;
        logic                              go;
    } csr_start_t;

    // one register word, seen either as a plain value
    // or as a start command
    typedef union packed {
        logic [31:0]                       word;
        csr_start_t                        start;
    } csr_word_u;

endpackage

`default_nettype wire

// ==== accel_bridge_settings.svh ====
/*
    width, address window and register offset macros for the
    accelerator memory bridge
*/

`ifndef ACCEL_BRIDGE_SETTINGS_SVH
`define ACCEL_BRIDGE_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////////////
// memory port widths
//////////////////////////////////////////////////////////////////////////////

// one line is 8 bytes wide
`define BRIDGE_DATA_WIDTH       64
`define BRIDGE_BYTEEN_WIDTH     8
// line address, byte offset bits stripped
`define BRIDGE_ADDR_WIDTH       29
`define BRIDGE_LINE_BITS        3
`define BRIDGE_TAG_WIDTH        8

//////////////////////////////////////////////////////////////////////////////
// local memory window
//////////////////////////////////////////////////////////////////////////////

// byte address, window is 16 KB
`define LOCAL_MEM_BASE          32'hF000_0000
`define LOCAL_MEM_SPACE_BITS    14

//////////////////////////////////////////////////////////////////////////////
// register block
//////////////////////////////////////////////////////////////////////////////

`define CSR_ADDR_WIDTH          4
`define CSR_BUSY_OFFSET         4'h0
`define CSR_START_OFFSET        4'h4
`define CSR_PC_OFFSET           4'h8
// boot address handed to the accelerator
`define PC_RESET_DEFAULT        32'hF000_0000

`endif
